// ==== include/rv_macros.svh ====
`ifndef RV_MACROS_SVH
`define RV_MACROS_SVH

// data path and pc width
`define RV_XLEN 32

// register address width and register count
`define RV_REG_AW 5
`define RV_NREGS 32

// sequential fetch increment
`define RV_PC_STEP 32'd4

`endif

// ==== design/rv_pkg.sv ====
`include "rv_macros.svh"

package rv_pkg;

    // kept major opcodes, RV32I encodings
    typedef enum logic [6:0] {
        OP_ILLEGAL = 7'b0000000,
        OP_R_TYPE  = 7'b0110011,
        OP_I_TYPE  = 7'b0010011,
        OP_LUI     = 7'b0110111,
        OP_AUIPC   = 7'b0010111,
        OP_JAL     = 7'b1101111,
        OP_JALR    = 7'b1100111,
        OP_BRANCH  = 7'b1100011
    } opcode_e;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR,
        ALU_SLL, ALU_SRL, ALU_SRA, ALU_SLT, ALU_SLTU
    } alu_op_e;

    // funct3 of the conditional branches
    typedef enum logic [2:0] {
        BR_BEQ  = 3'b000,
        BR_BNE  = 3'b001,
        BR_BLT  = 3'b100,
        BR_BGE  = 3'b101,
        BR_BLTU = 3'b110,
        BR_BGEU = 3'b111
    } branch_cond_e;

    typedef enum logic [1:0] {
        FETCH_START, FETCH_REQ, FETCH_WAIT, FETCH_HOLD
    } fetch_state_e;

    typedef struct packed {
        logic [31:0]         instr;
        logic [`RV_XLEN-1:0] pc;
    } fet_dec_t;

    typedef struct packed {
        opcode_e               opcode;
        logic [2:0]            funct3;
        logic                  funct7b5;
        logic [`RV_XLEN-1:0]   rs1_data;
        logic [`RV_XLEN-1:0]   rs2_data;
        logic [`RV_REG_AW-1:0] rd;
        logic [`RV_XLEN-1:0]   imm;
        logic [`RV_XLEN-1:0]   pc;
    } dec_exe_t;

    typedef struct packed {
        logic                  valid;
        logic [`RV_REG_AW-1:0] rd;
        logic [`RV_XLEN-1:0]   data;
    } wb_t;

    typedef struct packed {
        logic                taken;
        logic [`RV_XLEN-1:0] target;
    } redirect_t;

endpackage

// ==== design/fetch_fsm.sv ====
`timescale 1ns/1ps

module fetch_fsm (
    input  logic clk,
    input  logic rst_n,
    input  logic i_resp_valid,
    input  logic i_hold,
    input  logic i_resolved,
    input  logic i_dec_free,
    output logic o_req,
    output logic o_pc_step
);
    import rv_pkg::*;

    fetch_state_e state;
    fetch_state_e state_nxt;
    logic         handoff;

    // response taken by decode this cycle
    assign handoff = i_resp_valid && i_dec_free;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= FETCH_START;
        end else begin
            state <= state_nxt;
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            FETCH_START: state_nxt = FETCH_REQ;
            FETCH_REQ: begin
                // a transfer just entered decode, park until it resolves
                if (i_hold) begin
                    state_nxt = FETCH_HOLD;
                end else if (!handoff) begin
                    state_nxt = FETCH_WAIT;
                end
            end
            FETCH_WAIT: begin
                if (handoff) begin
                    state_nxt = FETCH_REQ;
                end
            end
            FETCH_HOLD: begin
                if (i_resolved) begin
                    state_nxt = FETCH_REQ;
                end
            end
            default: state_nxt = FETCH_START;
        endcase
    end

    assign o_req     = (state == FETCH_REQ) && !i_hold;
    // zero-delay response may land in the request cycle
    assign o_pc_step = handoff && (o_req || state == FETCH_WAIT);

endmodule

// ==== design/pc_counter.sv ====
`timescale 1ns/1ps
`include "rv_macros.svh"

module pc_counter (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                i_step,
    input  rv_pkg::redirect_t   i_redirect,
    output logic [`RV_XLEN-1:0] o_pc
);

    // redirect wins over a sequential step
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            o_pc <= '0;
        end else if (i_redirect.taken) begin
            o_pc <= i_redirect.target;
        end else if (i_step) begin
            o_pc <= o_pc + `RV_PC_STEP;
        end
    end

endmodule

// ==== design/instr_decode.sv ====
`timescale 1ns/1ps
`include "rv_macros.svh"

module instr_decode (
    input  logic [31:0]           i_instr,
    output rv_pkg::opcode_e       o_opcode,
    output logic [`RV_REG_AW-1:0] o_rs1,
    output logic [`RV_REG_AW-1:0] o_rs2,
    output logic [`RV_REG_AW-1:0] o_rd,
    output logic [2:0]            o_funct3,
    output logic                  o_funct7b5,
    output logic [`RV_XLEN-1:0]   o_imm,
    output logic                  o_ctrl_xfer
);
    import rv_pkg::*;

    logic [6:0] major;

    assign major      = i_instr[6:0];
    assign o_rd       = i_instr[11:7];
    assign o_funct3   = i_instr[14:12];
    assign o_rs1      = i_instr[19:15];
    assign o_rs2      = i_instr[24:20];
    assign o_funct7b5 = i_instr[30];

    // anything outside the kept set runs as a no-op
    always_comb begin
        if (major inside {OP_R_TYPE, OP_I_TYPE, OP_LUI, OP_AUIPC, OP_JAL, OP_JALR, OP_BRANCH}) begin
            o_opcode = opcode_e'(major);
        end else begin
            o_opcode = OP_ILLEGAL;
        end
    end

    always_comb begin
        case (o_opcode)
            OP_I_TYPE, OP_JALR: o_imm = {{20{i_instr[31]}}, i_instr[31:20]};
            OP_LUI, OP_AUIPC:   o_imm = {i_instr[31:12], 12'b0};
            OP_JAL: begin
                o_imm = {{12{i_instr[31]}}, i_instr[19:12], i_instr[20], i_instr[30:21], 1'b0};
            end
            OP_BRANCH: begin
                o_imm = {{20{i_instr[31]}}, i_instr[7], i_instr[30:25], i_instr[11:8], 1'b0};
            end
            default: o_imm = '0;
        endcase
    end

    assign o_ctrl_xfer = o_opcode inside {OP_JAL, OP_JALR, OP_BRANCH};

endmodule

// ==== design/exec_unit.sv ====
`timescale 1ns/1ps
`include "rv_macros.svh"

module exec_unit (
    input  logic              i_valid,
    input  rv_pkg::dec_exe_t  i_op,
    output rv_pkg::wb_t       o_wb,
    output rv_pkg::redirect_t o_redirect,
    output logic              o_resolved
);
    import rv_pkg::*;

    logic [`RV_XLEN-1:0] op_a;
    logic [`RV_XLEN-1:0] op_b;
    logic [`RV_XLEN-1:0] alu_res;
    logic [`RV_XLEN-1:0] pc_plus4;
    alu_op_e             alu_op;
    logic                is_jump;
    logic                writes_rd;
    logic                br_taken;

    // operand and operation select
    always_comb begin
        op_a   = i_op.rs1_data;
        op_b   = i_op.imm;
        alu_op = ALU_ADD;
        case (i_op.opcode)
            OP_R_TYPE, OP_I_TYPE: begin
                if (i_op.opcode == OP_R_TYPE) begin
                    op_b = i_op.rs2_data;
                end
                case (i_op.funct3)
                    3'b000:  alu_op = (i_op.opcode == OP_R_TYPE && i_op.funct7b5) ? ALU_SUB : ALU_ADD;
                    3'b001:  alu_op = ALU_SLL;
                    3'b010:  alu_op = ALU_SLT;
                    3'b011:  alu_op = ALU_SLTU;
                    3'b100:  alu_op = ALU_XOR;
                    3'b101:  alu_op = i_op.funct7b5 ? ALU_SRA : ALU_SRL;
                    3'b110:  alu_op = ALU_OR;
                    default: alu_op = ALU_AND;
                endcase
            end
            OP_BRANCH: begin
                op_b = i_op.rs2_data;
                case (branch_cond_e'(i_op.funct3))
                    BR_BLT, BR_BGE:   alu_op = ALU_SLT;
                    BR_BLTU, BR_BGEU: alu_op = ALU_SLTU;
                    default:          alu_op = ALU_SUB;
                endcase
            end
            OP_LUI:           op_a = '0;
            OP_AUIPC, OP_JAL: op_a = i_op.pc;
            default:          op_a = i_op.rs1_data;
        endcase
    end

    always_comb begin
        case (alu_op)
            ALU_SUB:  alu_res = op_a - op_b;
            ALU_AND:  alu_res = op_a & op_b;
            ALU_OR:   alu_res = op_a | op_b;
            ALU_XOR:  alu_res = op_a ^ op_b;
            ALU_SLL:  alu_res = op_a << op_b[4:0];
            ALU_SRL:  alu_res = op_a >> op_b[4:0];
            ALU_SRA:  alu_res = $signed(op_a) >>> op_b[4:0];
            ALU_SLT:  alu_res = {{(`RV_XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
            ALU_SLTU: alu_res = {{(`RV_XLEN-1){1'b0}}, op_a < op_b};
            default:  alu_res = op_a + op_b;
        endcase
    end

    // ge forms are the inverse of the lt compare
    always_comb begin
        case (branch_cond_e'(i_op.funct3))
            BR_BEQ:          br_taken = (alu_res == '0);
            BR_BNE:          br_taken = (alu_res != '0);
            BR_BLT, BR_BLTU: br_taken = alu_res[0];
            BR_BGE, BR_BGEU: br_taken = !alu_res[0];
            default:         br_taken = 1'b0;
        endcase
    end

    assign pc_plus4  = i_op.pc + `RV_PC_STEP;
    assign is_jump   = i_op.opcode inside {OP_JAL, OP_JALR};
    assign writes_rd = i_op.opcode inside {OP_R_TYPE, OP_I_TYPE, OP_LUI, OP_AUIPC, OP_JAL, OP_JALR};

    assign o_resolved        = i_valid && (is_jump || i_op.opcode == OP_BRANCH);
    assign o_redirect.taken  = o_resolved && (is_jump || br_taken);
    // jalr target is rs1 + imm with bit 0 dropped
    assign o_redirect.target = (i_op.opcode == OP_JALR) ? {alu_res[`RV_XLEN-1:1], 1'b0}
                                                        : i_op.pc + i_op.imm;

    assign o_wb.valid = i_valid && writes_rd && (i_op.rd != '0);
    assign o_wb.rd    = i_op.rd;
    assign o_wb.data  = is_jump ? pc_plus4 : alu_res;

endmodule

// ==== design/reg_file.sv ====
`timescale 1ns/1ps
`include "rv_macros.svh"

module reg_file (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic [`RV_REG_AW-1:0] i_rs1,
    input  logic [`RV_REG_AW-1:0] i_rs2,
    input  rv_pkg::wb_t           i_wb,
    output logic [`RV_XLEN-1:0]   o_rs1_data,
    output logic [`RV_XLEN-1:0]   o_rs2_data
);

    logic [`RV_XLEN-1:0] regs [`RV_NREGS];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `RV_NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (i_wb.valid && i_wb.rd != '0) begin
            regs[i_wb.rd] <= i_wb.data;
        end
    end

    // no write bypass, reader waits a cycle
    assign o_rs1_data = (i_rs1 == '0) ? '0 : regs[i_rs1];
    assign o_rs2_data = (i_rs2 == '0) ? '0 : regs[i_rs2];

endmodule

// ==== design/rv_ctrl_top.sv ====
`timescale 1ns/1ps
`include "rv_macros.svh"

module rv_ctrl_top (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                i_imem_valid,
    input  logic [31:0]         i_imem_rdata,
    output logic                o_imem_req,
    output logic [`RV_XLEN-1:0] o_imem_addr,
    output rv_pkg::wb_t         o_wb
);
    import rv_pkg::*;

    logic                  fet_pend;
    logic [31:0]           fet_buf;
    logic                  fet_valid;
    logic [`RV_XLEN-1:0]   pc;
    fet_dec_t              fet_dec_d;
    fet_dec_t              fet_dec_q;
    logic                  dec_busy;
    logic                  dec_wait;
    logic                  dec_valid;
    logic                  dec_ready;
    opcode_e               dec_opcode;
    logic [`RV_REG_AW-1:0] dec_rs1;
    logic [`RV_REG_AW-1:0] dec_rs2;
    logic [`RV_REG_AW-1:0] dec_rd;
    logic [2:0]            dec_funct3;
    logic                  dec_funct7b5;
    logic [`RV_XLEN-1:0]   dec_imm;
    logic                  dec_ctrl_xfer;
    logic [`RV_XLEN-1:0]   rs1_data;
    logic [`RV_XLEN-1:0]   rs2_data;
    dec_exe_t              dec_exe_d;
    dec_exe_t              dec_exe_q;
    logic                  exe_valid;
    wb_t                   exe_wb;
    redirect_t             exe_redirect;
    logic                  exe_resolved;
    logic                  fet_dec_we;
    logic                  dec_exe_we;
    logic                  pc_step;

    // fetch stage valid, response kept while decode is busy
    assign fet_valid = i_imem_valid || fet_pend;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            fet_pend <= 1'b0;
        end else if (fet_dec_we) begin
            fet_pend <= 1'b0;
        end else if (i_imem_valid) begin
            fet_pend <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (i_imem_valid) begin
            fet_buf <= i_imem_rdata;
        end
    end

    // handoff enables
    assign dec_ready  = !dec_busy || dec_exe_we;
    assign fet_dec_we = fet_valid && dec_ready;
    // execute never back-pressures
    assign dec_exe_we = dec_valid;

    assign fet_dec_d.instr = fet_pend ? fet_buf : i_imem_rdata;
    assign fet_dec_d.pc    = pc;

    always_ff @(posedge clk) begin
        if (fet_dec_we) begin
            fet_dec_q <= fet_dec_d;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            dec_busy <= 1'b0;
        end else if (fet_dec_we) begin
            dec_busy <= 1'b1;
        end else if (dec_exe_we) begin
            dec_busy <= 1'b0;
        end
    end

    // raw hazard on the instruction writing back this cycle
    assign dec_wait  = exe_wb.valid && (exe_wb.rd == dec_rs1 || exe_wb.rd == dec_rs2);
    assign dec_valid = dec_busy && !dec_wait;

    assign dec_exe_d.opcode   = dec_opcode;
    assign dec_exe_d.funct3   = dec_funct3;
    assign dec_exe_d.funct7b5 = dec_funct7b5;
    assign dec_exe_d.rs1_data = rs1_data;
    assign dec_exe_d.rs2_data = rs2_data;
    assign dec_exe_d.rd       = dec_rd;
    assign dec_exe_d.imm      = dec_imm;
    assign dec_exe_d.pc       = fet_dec_q.pc;

    always_ff @(posedge clk) begin
        if (dec_exe_we) begin
            dec_exe_q <= dec_exe_d;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            exe_valid <= 1'b0;
        end else begin
            exe_valid <= dec_exe_we;
        end
    end

    fetch_fsm u_fetch_fsm (
        .clk          (clk),
        .rst_n        (rst_n),
        .i_resp_valid (fet_valid),
        .i_hold       (dec_busy && dec_ctrl_xfer),
        .i_resolved   (exe_resolved),
        .i_dec_free   (dec_ready),
        .o_req        (o_imem_req),
        .o_pc_step    (pc_step)
    );

    pc_counter u_pc_counter (
        .clk        (clk),
        .rst_n      (rst_n),
        .i_step     (pc_step),
        .i_redirect (exe_redirect),
        .o_pc       (pc)
    );

    instr_decode u_instr_decode (
        .i_instr     (fet_dec_q.instr),
        .o_opcode    (dec_opcode),
        .o_rs1       (dec_rs1),
        .o_rs2       (dec_rs2),
        .o_rd        (dec_rd),
        .o_funct3    (dec_funct3),
        .o_funct7b5  (dec_funct7b5),
        .o_imm       (dec_imm),
        .o_ctrl_xfer (dec_ctrl_xfer)
    );

    exec_unit u_exec_unit (
        .i_valid    (exe_valid),
        .i_op       (dec_exe_q),
        .o_wb       (exe_wb),
        .o_redirect (exe_redirect),
        .o_resolved (exe_resolved)
    );

    reg_file u_reg_file (
        .clk        (clk),
        .rst_n      (rst_n),
        .i_rs1      (dec_rs1),
        .i_rs2      (dec_rs2),
        .i_wb       (exe_wb),
        .o_rs1_data (rs1_data),
        .o_rs2_data (rs2_data)
    );

    assign o_imem_addr = pc;
    assign o_wb        = exe_wb;

endmodule

// ==== verif/tb_checker.sv ====
`timescale 1ns/1ps
`include "rv_macros.svh"

module tb_checker #(
    parameter int N_WB = 27
) (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                i_imem_req,
    input  logic [`RV_XLEN-1:0] i_imem_addr,
    input  logic                i_imem_valid,
    input  rv_pkg::wb_t         i_wb,
    output logic                o_done,
    output int                  o_errors,
    output int                  o_wb_seen,
    output int                  o_fetch_seen
);

    localparam int N_TRACE = 41;

    // expected write-backs in program order, {rd, value}
    logic [36:0] exp_wb [N_WB];
    // word index of every fetch, the last one repeats forever
    int          trace [N_TRACE];
    logic        outstanding;
    logic        seen_resp;

    initial begin
        o_errors     = 0;
        o_wb_seen    = 0;
        o_fetch_seen = 0;
        outstanding  = 1'b0;
        seen_resp    = 1'b0;
        exp_wb = '{
            {5'd1,  32'h0000_0005},
            {5'd2,  32'hffff_fffd},
            {5'd3,  32'h0000_0002},
            {5'd4,  32'hffff_fff8},
            {5'd5,  32'h0000_0014},
            {5'd6,  32'h0000_0001},
            {5'd7,  32'h0000_0000},
            {5'd8,  32'hffff_fffd},
            {5'd9,  32'h3fff_fffe},
            {5'd10, 32'hffff_fffe},
            {5'd11, 32'hffff_fffd},
            {5'd12, 32'h3fff_fffc},
            {5'd13, 32'h0000_0001},
            {5'd14, 32'h0000_0001},
            {5'd15, 32'hffff_fffa},
            {5'd16, 32'h0000_0075},
            {5'd17, 32'h0000_00f0},
            {5'd18, 32'h5000_0000},
            {5'd19, 32'h0000_000f},
            {5'd20, 32'hffff_fffc},
            {5'd21, 32'h8000_1000},
            {5'd22, 32'h0000_1054},
            {5'd23, 32'h0000_0005},
            // jal link, then jalr base and link
            {5'd24, 32'h0000_00ac},
            {5'd25, 32'h0000_00c8},
            {5'd26, 32'h0000_00bc},
            {5'd27, 32'h0000_00bd}
        };
        trace = '{
            0, 1, 2, 3, 4, 5, 6, 7, 8, 9, 10, 11, 12,
            13, 14, 15, 16, 17, 18, 19, 20, 21, 22, 23, 24,
            26, 27, 29, 30, 32, 33, 35, 36, 38, 39, 41, 42,
            45, 46, 50, 51
        };
    end

    assign o_done = (o_wb_seen >= N_WB);

    always @(posedge clk) begin : sample
        int          tidx;
        logic [31:0] exp_addr;
        if (!rst_n) begin
            if (i_imem_req || i_wb.valid) begin
                $display("ERROR at %0t: request or write-back while reset is asserted", $time);
                o_errors = o_errors + 1;
            end
        end else begin
            if (i_wb.valid) begin
                if (!seen_resp) begin
                    $display("ERROR at %0t: write-back before the first instruction response",
                             $time);
                    o_errors = o_errors + 1;
                end else if (o_wb_seen >= N_WB) begin
                    $display("ERROR at %0t: write-back to x%0d past the end of the table",
                             $time, i_wb.rd);
                    o_errors = o_errors + 1;
                end else if (i_wb.rd !== exp_wb[o_wb_seen][36:32]
                             || i_wb.data !== exp_wb[o_wb_seen][31:0]) begin
                    $display("CHECK FAILED at %0t: write-back %0d expected x%0d = %h, got x%0d = %h",
                             $time, o_wb_seen, exp_wb[o_wb_seen][36:32],
                             exp_wb[o_wb_seen][31:0], i_wb.rd, i_wb.data);
                    o_errors = o_errors + 1;
                end
                o_wb_seen = o_wb_seen + 1;
            end
            if (i_imem_req) begin
                tidx     = (o_fetch_seen < N_TRACE) ? o_fetch_seen : N_TRACE - 1;
                exp_addr = trace[tidx] * 4;
                if (outstanding) begin
                    $display("ERROR at %0t: new request while a response is still outstanding",
                             $time);
                    o_errors = o_errors + 1;
                end
                if (i_imem_addr !== exp_addr) begin
                    $display("CHECK FAILED at %0t: fetch %0d expected address %h, got %h",
                             $time, o_fetch_seen, exp_addr, i_imem_addr);
                    o_errors = o_errors + 1;
                end
                o_fetch_seen = o_fetch_seen + 1;
                outstanding  = 1'b1;
            end
            // zero-delay response clears the request seen just above
            if (i_imem_valid) begin
                outstanding = 1'b0;
                seen_resp   = 1'b1;
            end
        end
    end

endmodule

// ==== verif/tb_top.sv ====
`timescale 1ns/1ps
`include "rv_macros.svh"

module tb_top;
    import rv_pkg::*;

    localparam int N_WB = 27;
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_IMM    = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;

    logic                clk;
    logic                rst_n;
    logic                imem_valid;
    logic [31:0]         imem_rdata;
    logic                imem_req;
    logic [`RV_XLEN-1:0] imem_addr;
    wb_t                 wb;
    logic [31:0]         imem [64];
    logic                done;
    int                  errors;
    int                  wb_seen;
    int                  fetch_seen;

    rv_ctrl_top dut0 (
        .clk          (clk),
        .rst_n        (rst_n),
        .i_imem_valid (imem_valid),
        .i_imem_rdata (imem_rdata),
        .o_imem_req   (imem_req),
        .o_imem_addr  (imem_addr),
        .o_wb         (wb)
    );

    tb_checker #(.N_WB(N_WB)) u_checker (
        .clk          (clk),
        .rst_n        (rst_n),
        .i_imem_req   (imem_req),
        .i_imem_addr  (imem_addr),
        .i_imem_valid (imem_valid),
        .i_wb         (wb),
        .o_done       (done),
        .o_errors     (errors),
        .o_wb_seen    (wb_seen),
        .o_fetch_seen (fetch_seen)
    );

    function automatic logic [31:0] r_word(input logic [6:0] f7, input logic [2:0] f3,
                                           input logic [4:0] rd, input logic [4:0] rs1,
                                           input logic [4:0] rs2);
        return {f7, rs2, rs1, f3, rd, OPC_OP};
    endfunction

    function automatic logic [31:0] i_word(input logic [6:0] opc, input logic [2:0] f3,
                                           input logic [4:0] rd, input logic [4:0] rs1,
                                           input logic [11:0] imm);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] u_word(input logic [6:0] opc, input logic [4:0] rd,
                                           input logic [19:0] imm);
        return {imm, rd, opc};
    endfunction

    function automatic logic [31:0] b_word(input logic [2:0] f3, input logic [4:0] rs1,
                                           input logic [4:0] rs2, input logic [12:0] off);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], OPC_BRANCH};
    endfunction

    function automatic logic [31:0] j_word(input logic [4:0] rd, input logic [20:0] off);
        return {off[20], off[10:1], off[11], off[19:12], rd, OPC_JAL};
    endfunction

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic load_program();
        // unused words hold an addi x31 tagged with their own index
        for (int i = 0; i < 64; i++) begin
            imem[i] = i_word(OPC_IMM, 3'b000, 5'd31, 5'd0, 12'h400 + 12'(i));
        end
        imem[0]  = i_word(OPC_IMM, 3'b000, 5'd1, 5'd0, 12'd5);
        imem[1]  = i_word(OPC_IMM, 3'b000, 5'd2, 5'd0, 12'hffd);
        imem[2]  = r_word(7'h00, 3'b000, 5'd3, 5'd1, 5'd2);
        imem[3]  = r_word(7'h20, 3'b000, 5'd4, 5'd2, 5'd1);
        imem[4]  = r_word(7'h00, 3'b001, 5'd5, 5'd1, 5'd3);
        imem[5]  = r_word(7'h00, 3'b010, 5'd6, 5'd2, 5'd1);
        imem[6]  = r_word(7'h00, 3'b011, 5'd7, 5'd2, 5'd1);
        imem[7]  = r_word(7'h00, 3'b100, 5'd8, 5'd4, 5'd1);
        imem[8]  = r_word(7'h00, 3'b101, 5'd9, 5'd4, 5'd3);
        imem[9]  = r_word(7'h20, 3'b101, 5'd10, 5'd4, 5'd3);
        imem[10] = r_word(7'h00, 3'b110, 5'd11, 5'd1, 5'd4);
        imem[11] = r_word(7'h00, 3'b111, 5'd12, 5'd2, 5'd9);
        imem[12] = i_word(OPC_IMM, 3'b010, 5'd13, 5'd2, 12'hffe);
        imem[13] = i_word(OPC_IMM, 3'b011, 5'd14, 5'd1, 12'hfff);
        imem[14] = i_word(OPC_IMM, 3'b100, 5'd15, 5'd1, 12'hfff);
        imem[15] = i_word(OPC_IMM, 3'b110, 5'd16, 5'd1, 12'h070);
        imem[16] = i_word(OPC_IMM, 3'b111, 5'd17, 5'd2, 12'h0f0);
        imem[17] = i_word(OPC_IMM, 3'b001, 5'd18, 5'd1, 12'd28);
        imem[18] = i_word(OPC_IMM, 3'b101, 5'd19, 5'd4, 12'd28);
        imem[19] = i_word(OPC_IMM, 3'b101, 5'd20, 5'd4, 12'h401);
        imem[20] = u_word(OPC_LUI, 5'd21, 20'h80001);
        imem[21] = u_word(OPC_AUIPC, 5'd22, 20'h00001);
        // write to x0 is dropped, then x0 is read back
        imem[22] = i_word(OPC_IMM, 3'b000, 5'd0, 5'd1, 12'd7);
        imem[23] = r_word(7'h00, 3'b000, 5'd23, 5'd0, 5'd1);
        // branch pairs, taken ones skip a tagged addi
        imem[24] = b_word(3'b000, 5'd1, 5'd23, 13'd8);
        imem[25] = i_word(OPC_IMM, 3'b000, 5'd31, 5'd0, 12'h111);
        imem[26] = b_word(3'b000, 5'd1, 5'd2, 13'd8);
        imem[27] = b_word(3'b001, 5'd1, 5'd2, 13'd8);
        imem[28] = i_word(OPC_IMM, 3'b000, 5'd31, 5'd0, 12'h222);
        imem[29] = b_word(3'b001, 5'd1, 5'd23, 13'd8);
        imem[30] = b_word(3'b100, 5'd2, 5'd1, 13'd8);
        imem[31] = i_word(OPC_IMM, 3'b000, 5'd31, 5'd0, 12'h333);
        imem[32] = b_word(3'b100, 5'd1, 5'd2, 13'd8);
        imem[33] = b_word(3'b101, 5'd1, 5'd2, 13'd8);
        imem[34] = i_word(OPC_IMM, 3'b000, 5'd31, 5'd0, 12'h444);
        imem[35] = b_word(3'b101, 5'd2, 5'd1, 13'd8);
        imem[36] = b_word(3'b110, 5'd1, 5'd2, 13'd8);
        imem[37] = i_word(OPC_IMM, 3'b000, 5'd31, 5'd0, 12'h555);
        imem[38] = b_word(3'b110, 5'd2, 5'd1, 13'd8);
        imem[39] = b_word(3'b111, 5'd2, 5'd1, 13'd8);
        imem[40] = i_word(OPC_IMM, 3'b000, 5'd31, 5'd0, 12'h666);
        imem[41] = b_word(3'b111, 5'd1, 5'd2, 13'd8);
        // jal over two words, jalr to byte 201 lands on word 50
        imem[42] = j_word(5'd24, 21'd12);
        imem[43] = i_word(OPC_IMM, 3'b000, 5'd31, 5'd0, 12'h777);
        imem[44] = i_word(OPC_IMM, 3'b000, 5'd31, 5'd0, 12'h788);
        imem[45] = i_word(OPC_IMM, 3'b000, 5'd25, 5'd0, 12'd200);
        imem[46] = i_word(OPC_JALR, 3'b000, 5'd26, 5'd25, 12'd1);
        imem[47] = i_word(OPC_IMM, 3'b000, 5'd31, 5'd0, 12'h799);
        imem[50] = i_word(OPC_IMM, 3'b000, 5'd27, 5'd26, 12'd1);
        // park on a self loop
        imem[51] = j_word(5'd0, 21'd0);
    endtask

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // instruction memory, answers 0 to 3 cycles after each request
    initial begin : imem_model
        logic [31:0] rng;
        int unsigned delay;
        rng        = 32'h42c4_2880;
        imem_valid = 1'b0;
        imem_rdata = '0;
        load_program();
        forever begin
            @(negedge clk);
            imem_valid = 1'b0;
            if (imem_req) begin
                rng   = xorshift32(rng);
                delay = rng % 4;
                repeat (delay) @(negedge clk);
                imem_valid = 1'b1;
                imem_rdata = imem[imem_addr[7:2]];
            end
        end
    end

    initial begin : run
        rst_n = 1'b0;
        repeat (4) @(negedge clk);
        rst_n = 1'b1;
        wait (done);
        // leave room for stray fetches or write-backs
        repeat (40) @(negedge clk);
        $display("tb_top: %0d errors, %0d of %0d write-backs, %0d fetches checked",
                 errors, wb_seen, N_WB, fetch_seen);
        if (errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

    initial begin : watchdog
        repeat (N_WB * 40) @(posedge clk);
        $display("ERROR: timeout, write-backs stopped after %0d of %0d table entries",
                 wb_seen, N_WB);
        $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

// ==== project.f ====
+incdir+include
design/rv_pkg.sv
design/fetch_fsm.sv
design/pc_counter.sv
design/instr_decode.sv
design/exec_unit.sv
design/reg_file.sv
design/rv_ctrl_top.sv
verif/tb_checker.sv
verif/tb_top.sv
